// File: glue_cfg.svh
////////////////////////////////////////
// Board glue configuration
// Widths, register map, reset values and fan timing
////////////////////////////////////////

`ifndef GLUE_CFG_SVH
`define GLUE_CFG_SVH

// Bus and field widths
`define GLUE_APB_ADDR_W       8
`define GLUE_APB_DATA_W       32
`define GLUE_BOOT_W           2
`define GLUE_FAN_W            4
`define GLUE_RTC_DIV_W        16

// Reset half period for a 50-cycle RTC period
`define GLUE_RTC_HALF_DEFAULT 24

// soc_clk cycles per PWM slot
`define GLUE_FAN_PRESCALE     4
`define GLUE_SYNC_STAGES      2

// Register offsets
`define GLUE_ADDR_CTRL        8'h00
`define GLUE_ADDR_RTC_DIV     8'h04
`define GLUE_ADDR_FAN_DUTY    8'h08
`define GLUE_ADDR_STATUS      8'h0C

// CTRL fields
`define GLUE_CTRL_SOFT_RST    0
`define GLUE_CTRL_BOOT_SEL    1
`define GLUE_CTRL_BOOT_MODE   3:2
`define GLUE_CTRL_FAN_SEL     4

// STATUS fields
`define GLUE_STAT_BOOT        1:0
`define GLUE_STAT_FAN         7:4

`endif

// File: glue_pkg.sv
////////////////////////////////////////
// Board glue types
// Data types shared by the glue blocks
////////////////////////////////////////

`include "glue_cfg.svh"

package glue_pkg;

  // APB bus
  typedef logic [`GLUE_APB_ADDR_W-1:0] apb_addr_t;
  typedef logic [`GLUE_APB_DATA_W-1:0] apb_data_t;

  // Boot mode as seen by the SoC
  typedef logic [`GLUE_BOOT_W-1:0] boot_mode_t;

  // Fan duty in sixteenths of a PWM period
  typedef logic [`GLUE_FAN_W-1:0] fan_duty_t;

  // RTC half period in soc_clk cycles less one
  typedef logic [`GLUE_RTC_DIV_W-1:0] rtc_div_t;

endpackage

// File: input_sync.sv
////////////////////////////////////////
// Input synchronizer
// Flop chain for asynchronous board inputs
////////////////////////////////////////

`timescale 1ns/100ps
`include "glue_cfg.svh"

module input_sync #(
  parameter type payload_t = logic
) (
  input  logic     soc_clk,
  input  logic     rst_n,
  input  payload_t async_i,
  output payload_t sync_o
);

  payload_t sync_q [`GLUE_SYNC_STAGES];

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `GLUE_SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      // First stage may go metastable
      sync_q[0] <= async_i;
      for (int i = 1; i < `GLUE_SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign sync_o = sync_q[`GLUE_SYNC_STAGES-1];

endmodule

// File: reset_sync.sv
////////////////////////////////////////
// SoC reset generator
// Board reset plus soft reset with synchronous release
////////////////////////////////////////

`timescale 1ns/100ps

module reset_sync (
  input  logic soc_clk,
  input  logic rst_n,
  input  logic soft_rst_i,
  output logic soc_rst_n_o
);

  logic [1:0] rst_q;

  // Async clear from the board and sync clear from software
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      rst_q <= '0;
    end else if (soft_rst_i) begin
      rst_q <= '0;
    end else begin
      rst_q <= {rst_q[0], 1'b1};
    end
  end

  // Release two edges after both sources go inactive
  assign soc_rst_n_o = rst_q[1];

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Soft reset reaches the SoC one cycle later at the latest
  soft_rst_asserts_a: assert property (
    @(posedge soc_clk) disable iff (!rst_n)
    soft_rst_i |=> !soc_rst_n_o
  );

endmodule

// File: glue_regs.sv
////////////////////////////////////////
// Glue register block
// APB slave for control, RTC divider, fan duty and status
////////////////////////////////////////

`timescale 1ns/100ps
`include "glue_cfg.svh"

module glue_regs (
  input  logic                 soc_clk,
  input  logic                 rst_n,
  // APB slave
  input  logic                 psel_i,
  input  logic                 penable_i,
  input  logic                 pwrite_i,
  input  glue_pkg::apb_addr_t  paddr_i,
  input  glue_pkg::apb_data_t  pwdata_i,
  output glue_pkg::apb_data_t  prdata_o,
  output logic                 pready_o,
  output logic                 pslverr_o,
  // Synchronized board switches
  input  glue_pkg::boot_mode_t boot_sw_i,
  input  glue_pkg::fan_duty_t  fan_sw_i,
  // Controls to the glue logic
  output logic                 soft_rst_o,
  output glue_pkg::boot_mode_t boot_mode_o,
  output glue_pkg::rtc_div_t   rtc_half_o,
  output glue_pkg::fan_duty_t  fan_duty_o
);

  logic                 access;
  logic                 wr_en;
  logic                 addr_hit;
  logic                 ctrl_soft_rst_q;
  logic                 ctrl_boot_sel_q;
  glue_pkg::boot_mode_t ctrl_boot_mode_q;
  logic                 ctrl_fan_sel_q;
  glue_pkg::rtc_div_t   rtc_div_q;
  glue_pkg::fan_duty_t  fan_duty_q;
  glue_pkg::apb_data_t  rdata;

  assign access = psel_i & penable_i;
  assign wr_en  = access & pwrite_i;

  ////////////////////////////////////////
  // Decode and read mux
  ////////////////////////////////////////

  always_comb begin
    rdata    = '0;
    addr_hit = 1'b1;
    case (paddr_i)
      `GLUE_ADDR_CTRL: begin
        rdata[`GLUE_CTRL_SOFT_RST]  = ctrl_soft_rst_q;
        rdata[`GLUE_CTRL_BOOT_SEL]  = ctrl_boot_sel_q;
        rdata[`GLUE_CTRL_BOOT_MODE] = ctrl_boot_mode_q;
        rdata[`GLUE_CTRL_FAN_SEL]   = ctrl_fan_sel_q;
      end
      `GLUE_ADDR_RTC_DIV: begin
        rdata[`GLUE_RTC_DIV_W-1:0] = rtc_div_q;
      end
      `GLUE_ADDR_FAN_DUTY: begin
        rdata[`GLUE_FAN_W-1:0] = fan_duty_q;
      end
      `GLUE_ADDR_STATUS: begin
        rdata[`GLUE_STAT_BOOT] = boot_sw_i;
        rdata[`GLUE_STAT_FAN]  = fan_sw_i;
      end
      default: begin
        addr_hit = 1'b0;
      end
    endcase
  end

  // No wait states
  assign pready_o  = 1'b1;
  assign prdata_o  = (access && !pwrite_i) ? rdata : '0;
  // STATUS is read only
  assign pslverr_o = access & (~addr_hit | (pwrite_i & (paddr_i == `GLUE_ADDR_STATUS)));

  ////////////////////////////////////////
  // Register writes
  ////////////////////////////////////////

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_soft_rst_q  <= 1'b0;
      ctrl_boot_sel_q  <= 1'b0;
      ctrl_boot_mode_q <= '0;
      ctrl_fan_sel_q   <= 1'b0;
      rtc_div_q        <= glue_pkg::rtc_div_t'(`GLUE_RTC_HALF_DEFAULT);
      fan_duty_q       <= '0;
    end else if (wr_en) begin
      case (paddr_i)
        `GLUE_ADDR_CTRL: begin
          ctrl_soft_rst_q  <= pwdata_i[`GLUE_CTRL_SOFT_RST];
          ctrl_boot_sel_q  <= pwdata_i[`GLUE_CTRL_BOOT_SEL];
          ctrl_boot_mode_q <= pwdata_i[`GLUE_CTRL_BOOT_MODE];
          ctrl_fan_sel_q   <= pwdata_i[`GLUE_CTRL_FAN_SEL];
        end
        `GLUE_ADDR_RTC_DIV: begin
          rtc_div_q <= pwdata_i[`GLUE_RTC_DIV_W-1:0];
        end
        `GLUE_ADDR_FAN_DUTY: begin
          fan_duty_q <= pwdata_i[`GLUE_FAN_W-1:0];
        end
        default: begin
        end
      endcase
    end
  end

  // Switch or register override
  assign soft_rst_o  = ctrl_soft_rst_q;
  assign boot_mode_o = ctrl_boot_sel_q ? ctrl_boot_mode_q : boot_sw_i;
  assign fan_duty_o  = ctrl_fan_sel_q ? fan_duty_q : fan_sw_i;
  assign rtc_half_o  = rtc_div_q;

  // Access phase only after a setup phase
  apb_setup_first_a: assert property (
    @(posedge soc_clk) disable iff (!rst_n)
    penable_i |-> $past(psel_i)
  );

endmodule

// File: rtc_divider.sv
////////////////////////////////////////
// RTC divider
// Toggles rtc_o every half_i+1 soc_clk cycles
////////////////////////////////////////

`timescale 1ns/100ps

module rtc_divider (
  input  logic               soc_clk,
  input  logic               soc_rst_n_i,
  input  glue_pkg::rtc_div_t half_i,
  output logic               rtc_o
);

  glue_pkg::rtc_div_t cnt_q;
  logic               rtc_q;
  logic               wrap;

  // Greater-or-equal so a lowered divider never strands the count
  assign wrap = (cnt_q >= half_i);

  always_ff @(posedge soc_clk or negedge soc_rst_n_i) begin
    if (!soc_rst_n_i) begin
      cnt_q <= '0;
      rtc_q <= 1'b0;
    end else if (wrap) begin
      cnt_q <= '0;
      rtc_q <= ~rtc_q;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign rtc_o = rtc_q;

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Count stays below all-ones unless the divider was programmed to it
  cnt_below_max_a: assert property (
    @(posedge soc_clk) disable iff (!soc_rst_n_i)
    (cnt_q == '1) |-> ($past(half_i) == '1)
  );

endmodule

// File: fan_pwm.sv
////////////////////////////////////////
// Fan PWM generator
// 16 slots of GLUE_FAN_PRESCALE cycles each
////////////////////////////////////////

`timescale 1ns/100ps
`include "glue_cfg.svh"

module fan_pwm (
  input  logic                soc_clk,
  input  logic                soc_rst_n_i,
  input  glue_pkg::fan_duty_t duty_i,
  output logic                fan_pwm_o
);

  localparam int unsigned PRESCALE = `GLUE_FAN_PRESCALE;
  localparam int unsigned PRE_W    = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;

  logic [PRE_W-1:0]    pre_q;
  logic                slot_step;
  glue_pkg::fan_duty_t slot_q;
  logic                pwm_q;

  // Last prescaler cycle of a slot
  assign slot_step = (pre_q == PRE_W'(PRESCALE - 1));

  always_ff @(posedge soc_clk or negedge soc_rst_n_i) begin
    if (!soc_rst_n_i) begin
      pre_q  <= '0;
      slot_q <= '0;
      pwm_q  <= 1'b0;
    end else begin
      pwm_q <= (slot_q < duty_i);
      if (slot_step) begin
        pre_q  <= '0;
        // Wraps after slot 15
        slot_q <= slot_q + 1'b1;
      end else begin
        pre_q <= pre_q + 1'b1;
      end
    end
  end

  assign fan_pwm_o = pwm_q;

  // Zero duty keeps the fan off
  zero_duty_off_a: assert property (
    @(posedge soc_clk) disable iff (!soc_rst_n_i)
    (duty_i == '0) |=> !fan_pwm_o
  );

endmodule

// File: fpga_glue_top.sv
////////////////////////////////////////
// FPGA board glue
// Reset, boot mode, RTC clock and fan control for the SoC
////////////////////////////////////////

`timescale 1ns/100ps

module fpga_glue_top (
  input  logic                 soc_clk,
  input  logic                 rst_n,
  // APB slave
  input  logic                 psel_i,
  input  logic                 penable_i,
  input  logic                 pwrite_i,
  input  glue_pkg::apb_addr_t  paddr_i,
  input  glue_pkg::apb_data_t  pwdata_i,
  output glue_pkg::apb_data_t  prdata_o,
  output logic                 pready_o,
  output logic                 pslverr_o,
  // Asynchronous board switches
  input  glue_pkg::boot_mode_t boot_mode_sw_i,
  input  glue_pkg::fan_duty_t  fan_sw_i,
  // To the SoC and the board
  output logic                 soc_rst_n_o,
  output glue_pkg::boot_mode_t boot_mode_o,
  output logic                 rtc_o,
  output logic                 fan_pwm_o
);

  glue_pkg::boot_mode_t boot_sw_sync;
  glue_pkg::fan_duty_t  fan_sw_sync;
  logic                 soft_rst;
  glue_pkg::rtc_div_t   rtc_half;
  glue_pkg::fan_duty_t  fan_duty;

  ////////////////////////////////////////
  // Switch synchronizers
  ////////////////////////////////////////

  input_sync #(
    .payload_t ( glue_pkg::boot_mode_t )
  ) u_boot_sync (
    .soc_clk ( soc_clk        ),
    .rst_n   ( rst_n          ),
    .async_i ( boot_mode_sw_i ),
    .sync_o  ( boot_sw_sync   )
  );

  input_sync #(
    .payload_t ( glue_pkg::fan_duty_t )
  ) u_fan_sync (
    .soc_clk ( soc_clk     ),
    .rst_n   ( rst_n       ),
    .async_i ( fan_sw_i    ),
    .sync_o  ( fan_sw_sync )
  );

  reset_sync u_reset_sync (
    .soc_clk     ( soc_clk     ),
    .rst_n       ( rst_n       ),
    .soft_rst_i  ( soft_rst    ),
    .soc_rst_n_o ( soc_rst_n_o )
  );

  ////////////////////////////////////////
  // Registers and generators
  ////////////////////////////////////////

  glue_regs u_glue_regs (
    .soc_clk     ( soc_clk      ),
    .rst_n       ( rst_n        ),
    .psel_i      ( psel_i       ),
    .penable_i   ( penable_i    ),
    .pwrite_i    ( pwrite_i     ),
    .paddr_i     ( paddr_i      ),
    .pwdata_i    ( pwdata_i     ),
    .prdata_o    ( prdata_o     ),
    .pready_o    ( pready_o     ),
    .pslverr_o   ( pslverr_o    ),
    .boot_sw_i   ( boot_sw_sync ),
    .fan_sw_i    ( fan_sw_sync  ),
    .soft_rst_o  ( soft_rst     ),
    .boot_mode_o ( boot_mode_o  ),
    .rtc_half_o  ( rtc_half     ),
    .fan_duty_o  ( fan_duty     )
  );

  // Both generators run from the SoC reset
  rtc_divider u_rtc_divider (
    .soc_clk     ( soc_clk     ),
    .soc_rst_n_i ( soc_rst_n_o ),
    .half_i      ( rtc_half    ),
    .rtc_o       ( rtc_o       )
  );

  fan_pwm u_fan_pwm (
    .soc_clk     ( soc_clk     ),
    .soc_rst_n_i ( soc_rst_n_o ),
    .duty_i      ( fan_duty    ),
    .fan_pwm_o   ( fan_pwm_o   )
  );

endmodule

// File: tb_fpga_glue.sv
////////////////////////////////////////
// Board glue testbench
// Replays APB, switch and measurement commands from a data file
////////////////////////////////////////

`timescale 1ns/100ps
`include "glue_cfg.svh"

module tb_fpga_glue;

  localparam string DATA_FILE   = "glue_testdata.txt";
  localparam int    NS_PER_LINE = 2000;
  localparam int    WAIT_LIMIT  = 16;
  localparam int    RTC_LIMIT   = 1000;

  logic                 soc_clk;
  logic                 rst_n;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  glue_pkg::apb_addr_t  paddr;
  glue_pkg::apb_data_t  pwdata;
  glue_pkg::apb_data_t  prdata;
  logic                 pready;
  logic                 pslverr;
  glue_pkg::boot_mode_t boot_sw;
  glue_pkg::fan_duty_t  fan_sw;
  logic                 soc_rst_n;
  glue_pkg::boot_mode_t boot_mode;
  logic                 rtc;
  logic                 fan_pwm;

  int                   errors;
  int                   checks;
  int                   line_count;
  // Expected CTRL contents and last driven boot switches
  glue_pkg::apb_data_t  ctrl_model;
  glue_pkg::boot_mode_t pins_boot;

  fpga_glue_top u_fpga_glue_top (
    .soc_clk        ( soc_clk   ),
    .rst_n          ( rst_n     ),
    .psel_i         ( psel      ),
    .penable_i      ( penable   ),
    .pwrite_i       ( pwrite    ),
    .paddr_i        ( paddr     ),
    .pwdata_i       ( pwdata    ),
    .prdata_o       ( prdata    ),
    .pready_o       ( pready    ),
    .pslverr_o      ( pslverr   ),
    .boot_mode_sw_i ( boot_sw   ),
    .fan_sw_i       ( fan_sw    ),
    .soc_rst_n_o    ( soc_rst_n ),
    .boot_mode_o    ( boot_mode ),
    .rtc_o          ( rtc       ),
    .fan_pwm_o      ( fan_pwm   )
  );

  initial begin
    soc_clk = 1'b0;
    forever #5 soc_clk = ~soc_clk;
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_data(input glue_pkg::apb_data_t got, input glue_pkg::apb_data_t exp,
                            input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t ns: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_boot(input glue_pkg::boot_mode_t got, input glue_pkg::boot_mode_t exp,
                            input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    checks++;
    if (got != exp) begin
      errors++;
      $display("mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Switches unless the CTRL override is selected
  function automatic glue_pkg::boot_mode_t expected_boot();
    return ctrl_model[`GLUE_CTRL_BOOT_SEL] ? ctrl_model[`GLUE_CTRL_BOOT_MODE] : pins_boot;
  endfunction

  ////////////////////////////////////////
  // APB master
  ////////////////////////////////////////

  task automatic apb_access(input logic wr, input glue_pkg::apb_addr_t addr,
                            input glue_pkg::apb_data_t wdata,
                            output glue_pkg::apb_data_t rdata, output logic err);
    int waits;
    @(posedge soc_clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge soc_clk);
    penable <= 1'b1;
    waits = 0;
    @(negedge soc_clk);
    while (!pready && waits < WAIT_LIMIT) begin
      @(negedge soc_clk);
      waits++;
    end
    rdata = prdata;
    err   = pslverr;
    if (!pready) begin
      errors++;
      $display("APB %s at address %h never completed, pready stayed low",
               wr ? "write" : "read", addr);
    end
    @(posedge soc_clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic write_reg(input glue_pkg::apb_addr_t addr, input glue_pkg::apb_data_t data);
    glue_pkg::apb_data_t rdata;
    logic                err;
    logic                exp_err;
    exp_err = !(addr == `GLUE_ADDR_CTRL || addr == `GLUE_ADDR_RTC_DIV ||
                addr == `GLUE_ADDR_FAN_DUTY);
    apb_access(1'b1, addr, data, rdata, err);
    check_flag(err, exp_err, $sformatf("pslverr on write to %h", addr));
    if (addr == `GLUE_ADDR_CTRL) begin
      // CTRL implements bits 4:0
      ctrl_model = data & 32'h1F;
    end
    @(negedge soc_clk);
    check_boot(boot_mode, expected_boot(), "boot_mode_o after write");
  endtask

  task automatic read_reg(input glue_pkg::apb_addr_t addr, input glue_pkg::apb_data_t exp,
                          input logic exp_err);
    glue_pkg::apb_data_t rdata;
    logic                err;
    apb_access(1'b0, addr, '0, rdata, err);
    check_data(rdata, exp, $sformatf("register %h", addr));
    check_flag(err, exp_err, $sformatf("pslverr on read of %h", addr));
  endtask

  ////////////////////////////////////////
  // Pins and measurements
  ////////////////////////////////////////

  task automatic drive_pins(input glue_pkg::boot_mode_t boot, input glue_pkg::fan_duty_t fan);
    @(posedge soc_clk);
    boot_sw <= boot;
    fan_sw  <= fan;
    pins_boot = boot;
    // Two synchronizer stages plus margin
    repeat (3) @(posedge soc_clk);
    @(negedge soc_clk);
    check_boot(boot_mode, expected_boot(), "boot_mode_o after pins change");
  endtask

  task automatic wait_rtc_rise(output int cycles, output logic ok);
    logic prev;
    cycles = 0;
    ok     = 1'b0;
    prev   = rtc;
    while (!ok && cycles < RTC_LIMIT) begin
      @(negedge soc_clk);
      cycles++;
      if (rtc && !prev) ok = 1'b1;
      prev = rtc;
    end
  endtask

  task automatic measure_rtc(input int exp_period);
    int   cycles;
    logic ok;
    ok = 1'b1;
    @(negedge soc_clk);
    // First rise may end a partial period and the next full one is skipped
    for (int i = 0; i < 3; i++) begin
      if (ok) wait_rtc_rise(cycles, ok);
    end
    if (!ok) begin
      errors++;
      $display("rtc_o stopped toggling, no rising edge within %0d cycles", RTC_LIMIT);
    end else begin
      check_count(cycles, exp_period, "rtc_o period in cycles");
    end
  endtask

  task automatic measure_pwm(input int exp_high);
    int high;
    high = 0;
    // Let a recent duty change reach the output
    repeat (2) @(posedge soc_clk);
    repeat (64) begin
      @(negedge soc_clk);
      if (fan_pwm) high++;
    end
    check_count(high, exp_high, "fan_pwm_o high cycles in 64");
  endtask

  task automatic pulse_soft_reset();
    glue_pkg::apb_data_t keep;
    glue_pkg::apb_data_t set_val;
    glue_pkg::apb_data_t rdata;
    logic                err;
    int                  n;
    keep = ctrl_model;
    keep[`GLUE_CTRL_SOFT_RST] = 1'b0;
    set_val = keep;
    set_val[`GLUE_CTRL_SOFT_RST] = 1'b1;
    write_reg(`GLUE_ADDR_CTRL, set_val);
    @(posedge soc_clk);
    @(negedge soc_clk);
    check_flag(soc_rst_n, 1'b0, "soc_rst_n_o with soft reset set");
    write_reg(`GLUE_ADDR_CTRL, keep);
    n = 0;
    while (!soc_rst_n && n < 3) begin
      @(posedge soc_clk);
      @(negedge soc_clk);
      n++;
    end
    check_flag(soc_rst_n, 1'b1, "soc_rst_n_o three cycles after soft reset release");
    apb_access(1'b0, `GLUE_ADDR_CTRL, '0, rdata, err);
    check_data(rdata, ctrl_model, "CTRL after soft reset");
  endtask

  ////////////////////////////////////////
  // Data file replay
  ////////////////////////////////////////

  task automatic count_lines(output int n);
    int               fd;
    int               code;
    logic [8*128-1:0] buffer;
    n  = 0;
    fd = $fopen(DATA_FILE, "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        code = $fgets(buffer, fd);
        if (code > 0) n++;
      end
      $fclose(fd);
    end
  endtask

  task automatic replay_file();
    int                   fd;
    int                   code;
    logic [63:0]          cmd;
    logic [8*128-1:0]     rest;
    glue_pkg::apb_addr_t  addr;
    glue_pkg::apb_data_t  data;
    logic                 exp_err;
    glue_pkg::boot_mode_t boot_v;
    glue_pkg::fan_duty_t  fan_v;
    int                   count_v;
    fd   = $fopen(DATA_FILE, "r");
    code = 1;
    while (code == 1) begin
      cmd  = '0;
      code = $fscanf(fd, "%s", cmd);
      if (code == 1) begin
        if (cmd == "#") begin
          code = $fgets(rest, fd);
          code = 1;
        end else if (cmd == "write") begin
          code = $fscanf(fd, "%h %h", addr, data);
          write_reg(addr, data);
          code = 1;
        end else if (cmd == "read") begin
          code = $fscanf(fd, "%h %h %h", addr, data, exp_err);
          read_reg(addr, data, exp_err);
          code = 1;
        end else if (cmd == "pins") begin
          code = $fscanf(fd, "%h %h", boot_v, fan_v);
          drive_pins(boot_v, fan_v);
          code = 1;
        end else if (cmd == "rtc") begin
          code = $fscanf(fd, "%d", count_v);
          measure_rtc(count_v);
          code = 1;
        end else if (cmd == "pwm") begin
          code = $fscanf(fd, "%d", count_v);
          measure_pwm(count_v);
          code = 1;
        end else if (cmd == "soft") begin
          pulse_soft_reset();
        end else begin
          errors++;
          $display("unknown command in data file, replay stopped");
          code = 0;
        end
      end
    end
    $fclose(fd);
  endtask

  // Budget grows with the length of the data file
  initial begin
    wait (line_count > 0);
    #(line_count * NS_PER_LINE);
    $display("timeout after %0d ns, the data file replay did not finish",
             line_count * NS_PER_LINE);
    $display("Test failures found");
    $finish;
  end

  initial begin
    rst_n      = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    boot_sw    = '0;
    fan_sw     = '0;
    errors     = 0;
    checks     = 0;
    line_count = 0;
    ctrl_model = '0;
    pins_boot  = '0;
    count_lines(line_count);
    if (line_count == 0) begin
      errors++;
      $display("data file %s is missing or empty", DATA_FILE);
    end else begin
      repeat (16) @(posedge soc_clk);
      rst_n <= 1'b1;
      replay_file();
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: glue_testdata.txt
# Columns: write addr data | read addr exp_data exp_slverr | pins boot fan
# rtc exp_period | pwm exp_high_count | soft ; addr, data and pins in hex, counts decimal
pins 2 9
read 00 00000000 0
read 04 00000018 0
read 08 00000000 0
read 0C 00000092 0
rtc 50
pwm 36
write 08 00000005
write 04 00000009
read 04 00000009 0
read 08 00000005 0
write 10 DEADBEEF
read 10 00000000 1
write 0C 000000FF
read 0C 00000092 0
read 00 00000000 0
read 04 00000009 0
read 08 00000005 0
rtc 20
pwm 36
write 00 00000010
pwm 20
pins 1 3
read 0C 00000031 0
write 00 0000001A
read 00 0000001A 0
pins 3 C
pwm 20
write 04 0000000E
read 04 0000000E 0
rtc 30
soft
rtc 30
write 00 00000000
pwm 48
read 0C 000000C3 0

// File: build.f
+incdir+.
glue_pkg.sv
input_sync.sv
reset_sync.sv
glue_regs.sv
rtc_divider.sv
fan_pwm.sv
fpga_glue_top.sv
tb_fpga_glue.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the board glue testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module tb_fpga_glue -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vtb_fpga_glue > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test failures found" "$LOG"; then
  exit 1
fi
exit 0
